//--- compile.f
rtl/fphub_pkg.sv
rtl/sqrt_control_fsm.sv
rtl/iteration_counter.sv
rtl/operand_prep.sv
rtl/residual_cs.sv
rtl/root_otf.sv
rtl/root_normalize.sv
rtl/fphub_sqrt.sv
tests/tb_fphub_sqrt.sv

//--- rtl/fphub_pkg.sv
package fphub_pkg;

    // Operand format
    localparam int EXP_W    = 8;                    // Exponent bits
    localparam int MAN_W    = 23;                   // Stored mantissa bits
    localparam int SIG_W    = MAN_W + 2;            // Implicit one, mantissa, implicit LSB
    localparam int EXP_BIAS = 1 << (EXP_W - 1);     // Half of 2**EXP_W

    // Recurrence sizing
    localparam int ITERATIONS = 26;                 // Steps after the load step
    localparam int RES_FRAC   = 27;                 // Fraction bits of the residual
    localparam int RES_W      = RES_FRAC + 4;       // Sign, three integer bits, fraction
    localparam int ROOT_W     = 28;                 // Root bit k weighs 2**(k-27)
    localparam int EST_W      = 5;                  // 2w estimate, one fraction bit

    typedef logic [EXP_W+MAN_W:0] fp_word_t;        // Sign, exponent, mantissa
    typedef logic [EXP_W-1:0]     exp_t;
    typedef logic [MAN_W-1:0]     man_t;
    typedef logic [SIG_W-1:0]     sig_t;
    typedef logic [RES_W-1:0]     resid_t;          // One carry-save vector
    typedef logic [ROOT_W-1:0]    root_t;
    typedef logic [EST_W-1:0]     est_t;
    typedef logic [1:0]           digit_t;
    typedef logic [4:0]           step_t;

    // Signed digit codes
    localparam digit_t DIG_ZERO = 2'b00;
    localparam digit_t DIG_POS  = 2'b01;
    localparam digit_t DIG_NEG  = 2'b11;

    // Controller states
    typedef enum logic [1:0] {
        IDLE,
        ITERATE,
        CONVERT,
        DONE
    } sqrt_state_t;

endpackage

//--- rtl/fphub_sqrt.sv
module fphub_sqrt
    import fphub_pkg::*;
#(
    parameter int ITERATIONS = fphub_pkg::ITERATIONS
) (
    input  logic     clk,
    input  logic     rst_l,
    input  logic     start,
    input  fp_word_t x,
    output fp_word_t res,
    output logic     finish,
    output logic     computing
);

    // Controller strobes
    logic   load;
    logic   step;
    logic   convert;
    logic   last_step;

    // Datapath
    resid_t x_scaled;
    exp_t   res_exp;
    digit_t digit;
    logic   resid_neg;
    resid_t sub_pos;
    resid_t sub_neg;
    root_t  root_q;
    root_t  root_qm;

    sqrt_control_fsm u_fsm (
        .clk       (clk),
        .rst_l     (rst_l),
        .start     (start),
        .last_step (last_step),
        .load      (load),
        .step      (step),
        .convert   (convert),
        .computing (computing),
        .finish    (finish)
    );

    iteration_counter #(
        .ITERATIONS (ITERATIONS)
    ) u_counter (
        .clk       (clk),
        .rst_l     (rst_l),
        .load      (load),
        .step      (step),
        .last_step (last_step)
    );

    operand_prep u_prep (
        .clk      (clk),
        .rst_l    (rst_l),
        .load     (load),
        .x        (x),
        .x_scaled (x_scaled),
        .res_exp  (res_exp)
    );

    residual_cs u_resid (
        .clk       (clk),
        .rst_l     (rst_l),
        .load      (load),
        .step      (step),
        .x_scaled  (x_scaled),
        .sub_pos   (sub_pos),
        .sub_neg   (sub_neg),
        .digit     (digit),
        .resid_neg (resid_neg)
    );

    root_otf u_root (
        .clk     (clk),
        .rst_l   (rst_l),
        .load    (load),
        .step    (step),
        .digit   (digit),
        .sub_pos (sub_pos),
        .sub_neg (sub_neg),
        .root_q  (root_q),
        .root_qm (root_qm)
    );

    root_normalize u_norm (
        .clk       (clk),
        .rst_l     (rst_l),
        .convert   (convert),
        .resid_neg (resid_neg),
        .root_q    (root_q),
        .root_qm   (root_qm),
        .res_exp   (res_exp),
        .res       (res)
    );

endmodule

//--- rtl/iteration_counter.sv
module iteration_counter
    import fphub_pkg::*;
#(
    parameter int ITERATIONS = fphub_pkg::ITERATIONS
) (
    input  logic clk,
    input  logic rst_l,
    input  logic load,
    input  logic step,
    output logic last_step
);

    step_t idx;     // Index of the step in progress

    // High during the final ITERATE cycle
    assign last_step = (idx == step_t'(ITERATIONS));

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            idx <= '0;
        end else if (load) begin
            idx <= step_t'(1);          // First step runs on the next edge
        end else if (step) begin
            idx <= idx + step_t'(1);
        end
    end

endmodule

//--- rtl/operand_prep.sv
module operand_prep
    import fphub_pkg::*;
(
    input  logic     clk,
    input  logic     rst_l,
    input  logic     load,
    input  fp_word_t x,
    output resid_t   x_scaled,
    output exp_t     res_exp
);

    exp_t             x_exp;
    man_t             x_man;
    sig_t             sig;
    resid_t           sig_res;
    logic [EXP_W:0]   exp_sum;

    assign x_exp = x[EXP_W+MAN_W-1:MAN_W];
    assign x_man = x[MAN_W-1:0];

    // HUB significand, both implicit ones
    assign sig = {1'b1, x_man, 1'b1};

    // Leading one lands on the unit bit of the residual
    assign sig_res = resid_t'({sig, 3'b000});

    // Odd exponent gives x in [0.5,1), even gives [0.25,0.5)
    assign x_scaled = x_exp[0] ? (sig_res >> 1) : (sig_res >> 2);

    // Halved exponent with half bias restored
    assign exp_sum = {1'b0, x_exp} + (EXP_W+1)'(EXP_BIAS);

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            res_exp <= '0;
        end else if (load) begin
            res_exp <= exp_sum[EXP_W:1];    // Floor of the half
        end
    end

endmodule

//--- rtl/residual_cs.sv
module residual_cs
    import fphub_pkg::*;
(
    input  logic   clk,
    input  logic   rst_l,
    input  logic   load,
    input  logic   step,
    input  resid_t x_scaled,
    input  resid_t sub_pos,
    input  resid_t sub_neg,
    output digit_t digit,
    output logic   resid_neg
);

    // Weight of 2**-1 in residual format
    localparam resid_t HALF = resid_t'(1) << (RES_FRAC - 1);

    resid_t sum_r;          // Carry-save residual
    resid_t carry_r;
    resid_t sum2;
    resid_t carry2;
    resid_t sub_sel;
    resid_t sum_nxt;
    resid_t carry_nxt;
    resid_t w_full;
    est_t   est;

    // Doubled residual, plain shift of both vectors
    assign sum2   = sum_r << 1;
    assign carry2 = carry_r << 1;

    // Top bits of 2w, truncated to half units
    assign est = sum_r[RES_W-2 -: EST_W] + carry_r[RES_W-2 -: EST_W];

    always_comb begin
        if (est == '1) begin
            digit = DIG_ZERO;           // Estimate is -1/2
        end else if (!est[EST_W-1]) begin
            digit = DIG_POS;            // Non-negative
        end else begin
            digit = DIG_NEG;
        end
    end

    always_comb begin
        case (digit)
            DIG_POS: sub_sel = sub_pos;
            DIG_NEG: sub_sel = sub_neg;
            default: sub_sel = '0;
        endcase
    end

    // 3:2 compression of 2w and the subtrahend
    assign sum_nxt   = sum2 ^ carry2 ^ sub_sel;
    assign carry_nxt = ((sum2 & carry2) | (sum2 & sub_sel) | (carry2 & sub_sel)) << 1;

    // Assimilated residual, only its sign is used
    assign w_full    = sum_r + carry_r;
    assign resid_neg = w_full[RES_W-1];

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            sum_r   <= '0;
            carry_r <= '0;
        end else if (load) begin
            sum_r   <= (x_scaled << 1) - HALF;  // First digit is always +1
            carry_r <= '0;
        end else if (step) begin
            sum_r   <= sum_nxt;
            carry_r <= carry_nxt;
        end
    end

endmodule

//--- rtl/root_normalize.sv
module root_normalize
    import fphub_pkg::*;
(
    input  logic     clk,
    input  logic     rst_l,
    input  logic     convert,
    input  logic     resid_neg,
    input  root_t    root_q,
    input  root_t    root_qm,
    input  exp_t     res_exp,
    output fp_word_t res
);

    localparam int LZ_W = $clog2(ROOT_W + 1);

    root_t           root_sel;
    root_t           root_norm;
    logic [LZ_W-1:0] lz;
    logic            found;
    man_t            res_man;

    // Negative final residual means the root overshot by one unit
    assign root_sel = resid_neg ? root_qm : root_q;

    // Leading zero count from the MSB down
    always_comb begin
        lz    = '0;
        found = 1'b0;
        for (int i = ROOT_W - 1; i >= 0; i--) begin
            if (!found) begin
                if (root_sel[i]) begin
                    found = 1'b1;
                end else begin
                    lz = lz + LZ_W'(1);
                end
            end
        end
    end

    // Leading one shifted to the top and dropped
    assign root_norm = root_sel << lz;
    assign res_man   = root_norm[ROOT_W-2 -: MAN_W];

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            res <= '0;
        end else if (convert) begin
            res <= {1'b0, res_exp, res_man};    // Always positive
        end
    end

endmodule

//--- rtl/root_otf.sv
module root_otf
    import fphub_pkg::*;
(
    input  logic   clk,
    input  logic   rst_l,
    input  logic   load,
    input  logic   step,
    input  digit_t digit,
    output resid_t sub_pos,
    output resid_t sub_neg,
    output root_t  root_q,
    output root_t  root_qm
);

    root_t  q_r;            // Root so far
    root_t  qm_r;           // Root minus one unit
    root_t  pos_r;          // One-hot slot of the next digit
    root_t  above_r;        // Bits already settled
    resid_t marker;
    resid_t settled;
    resid_t q_inv;

    assign root_q  = q_r;
    assign root_qm = qm_r;

    // Two ones at 2**-j and 2**-(j+1) of the doubled root
    assign marker  = resid_t'({pos_r, 1'b0}) | resid_t'(pos_r);

    // Settled prefix plus the sign extension bits
    assign settled = ~resid_t'({~above_r, 1'b1});
    assign q_inv   = ~resid_t'({q_r, 1'b0});

    // -(2q + 2**-(j+1)) and 2q - 2**-(j+1)
    assign sub_pos = (q_inv & settled) | marker;
    assign sub_neg = resid_t'({qm_r, 1'b0}) | marker;

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            q_r     <= '0;
            qm_r    <= '0;
            pos_r   <= '0;
            above_r <= '0;
        end else if (load) begin
            q_r     <= root_t'(1) << (ROOT_W - 2);     // q = 0.1
            qm_r    <= '0;
            pos_r   <= root_t'(1) << (ROOT_W - 3);
            above_r <= {2'b11, {(ROOT_W-2){1'b0}}};
        end else if (step) begin
            case (digit)
                DIG_POS: begin
                    q_r  <= q_r | pos_r;
                    qm_r <= q_r;
                end
                DIG_NEG: begin
                    q_r  <= qm_r | pos_r;
                    qm_r <= qm_r;               // Unchanged prefix
                end
                default: begin
                    qm_r <= qm_r | pos_r;
                end
            endcase
            pos_r   <= pos_r >> 1;
            above_r <= above_r | pos_r;
        end
    end

endmodule

//--- rtl/sqrt_control_fsm.sv
module sqrt_control_fsm
    import fphub_pkg::*;
(
    input  logic clk,
    input  logic rst_l,
    input  logic start,
    input  logic last_step,
    output logic load,
    output logic step,
    output logic convert,
    output logic computing,
    output logic finish
);

    sqrt_state_t state;
    sqrt_state_t state_nxt;

    // Start is only honoured in IDLE
    assign load      = start && (state == IDLE);
    assign step      = (state == ITERATE);
    assign convert   = (state == CONVERT);
    assign computing = (state == ITERATE) || (state == CONVERT);
    assign finish    = (state == DONE);     // One cycle, res valid

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (start) state_nxt = ITERATE;
            ITERATE: if (last_step) state_nxt = CONVERT;
            CONVERT: state_nxt = DONE;
            DONE:    state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, pass only if the log holds the pass line
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_fphub_sqrt -o tb_fphub_sqrt -f compile.f > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/tb_fphub_sqrt > sim.log 2>&1 || echo "Simulator returned an error status"

grep -q "^Done: no errors$" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }

//--- tests/tb_fphub_sqrt.sv
module tb_fphub_sqrt
    import fphub_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_STEPS      = ITERATIONS;    // Recurrence steps of the DUT
    localparam int NUM_RANDOM     = 300;
    localparam int FINISH_TIMEOUT = 100;           // Cycles the compare process waits
    localparam int DRAIN_TIMEOUT  = 150;           // Cycles the stimulus waits

    logic     clk;
    logic     rst_l;
    logic     start;
    fp_word_t x;
    fp_word_t res;
    logic     finish;
    logic     computing;

    fp_word_t pending[$];   // Operands issued oldest first
    int       checks      = 0;
    int       errors      = 0;
    int       timeouts    = 0;
    int       ops_done    = 0;
    int       finish_seen = 0;

    fphub_sqrt #(
        .ITERATIONS (NUM_STEPS)
    ) uut (
        .clk       (clk),
        .rst_l     (rst_l),
        .start     (start),
        .x         (x),
        .res       (res),
        .finish    (finish),
        .computing (computing)
    );

    always #20 clk = ~clk;  // 40 ns period

    // Expected root from the integer square root of the scaled HUB significand
    function automatic fp_word_t sqrt_ref(input fp_word_t op);
        exp_t        e;
        man_t        m;
        logic [63:0] p;
        logic [63:0] r;
        logic [63:0] trial;
        exp_t        r_exp;
        e = op[EXP_W+MAN_W-1:MAN_W];
        m = op[MAN_W-1:0];
        p = 64'({1'b1, m, 1'b1});
        if (e[0]) begin
            p = p << 23;        // Odd exponent
        end else begin
            p = p << 22;
        end
        r = '0;
        for (int b = 31; b >= 0; b--) begin
            trial = r | (64'd1 << b);
            if (trial * trial <= p) begin
                r = trial;      // Keep this bit
            end
        end
        r_exp = exp_t'((int'(e) + EXP_BIAS) / 2);
        return {1'b0, r_exp, r[MAN_W-1:0]};     // Leading one dropped
    endfunction

    // Counts every cycle with finish high
    always @(negedge clk) begin
        if (finish === 1'b1) begin
            finish_seen++;
        end
    end

    // Compare process samples at the falling edge
    initial begin : compare
        fp_word_t op;
        fp_word_t expected;
        int       waited;
        int       busy;
        forever begin
            @(negedge clk);
            if (pending.size() > 0) begin
                op     = pending[0];
                waited = 0;
                busy   = 0;
                while (finish !== 1'b1 && waited < FINISH_TIMEOUT) begin
                    if (computing === 1'b1) begin
                        busy++;
                    end
                    @(negedge clk);
                    waited++;
                end
                if (finish !== 1'b1) begin
                    timeouts++;
                    $display("Timed out after %0d cycles waiting for finish, operand %h",
                             FINISH_TIMEOUT, op);
                end else begin
                    expected = sqrt_ref(op);
                    ops_done++;
                    checks++;
                    assert (res === expected) else begin
                        errors++;
                        $display("Error %0t: x=%h expected %h got %h",
                                 $time, op, expected, res);
                    end
                    checks++;
                    assert (busy == NUM_STEPS + 1) else begin
                        errors++;
                        $display("Error %0t: x=%h computing high %0d cycles, expected %0d",
                                 $time, op, busy, NUM_STEPS + 1);
                    end
                    checks++;
                    assert (computing === 1'b0) else begin
                        errors++;
                        $display("Error %0t: x=%h computing still high with finish",
                                 $time, op);
                    end
                end
                void'(pending.pop_front());
                @(negedge clk);
                checks++;
                assert (finish === 1'b0) else begin    // Pulse is one cycle wide
                    errors++;
                    $display("Error %0t: x=%h finish high a second cycle", $time, op);
                end
            end
        end
    end

    // One start pulse driven just after the edge
    task automatic issue_op(input fp_word_t op);
        @(posedge clk);
        #2;
        x     = op;
        start = 1'b1;
        pending.push_back(op);
        @(posedge clk);
        #2;
        start = 1'b0;
    endtask

    // Until the compare process has taken every operand
    task automatic wait_drained();
        int waited;
        waited = 0;
        while (pending.size() > 0 && waited < DRAIN_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (pending.size() > 0) begin
            timeouts++;
            $display("Timed out after %0d cycles waiting for the result to be checked",
                     DRAIN_TIMEOUT);
        end
    endtask

    task automatic run_op(input fp_word_t op);
        if (timeouts == 0) begin
            issue_op(op);
            wait_drained();
        end
    endtask

    // Second start mid-operation must be ignored
    task automatic busy_start_test(input fp_word_t op_a, input fp_word_t op_b);
        issue_op(op_a);
        repeat (5) @(negedge clk);
        checks++;
        assert (computing === 1'b1) else begin
            errors++;
            $display("Error %0t: computing low before the second start", $time);
        end
        @(posedge clk);
        #2;
        x     = op_b;
        start = 1'b1;           // Not queued as no result is expected
        @(posedge clk);
        #2;
        start = 1'b0;
        wait_drained();
        for (int c = 0; c < 2 * (NUM_STEPS + 2); c++) begin
            @(negedge clk);
            checks++;
            assert (finish === 1'b0 && computing === 1'b0) else begin
                errors++;
                $display("Error %0t: activity after the ignored start, finish=%b computing=%b",
                         $time, finish, computing);
            end
        end
    endtask

    initial begin : stimulus
        exp_t        e;
        man_t        m;
        int unsigned first_draw;
        clk        = 1'b0;
        rst_l      = 1'b0;
        start      = 1'b0;
        x          = '0;
        first_draw = $urandom(32'habfb);    // Seeds the run
        repeat (5) @(posedge clk);
        #2;
        rst_l = 1'b1;

        // Outputs idle after reset
        @(negedge clk);
        checks++;
        assert (res === '0) else begin
            errors++;
            $display("Error %0t: res after reset is %h", $time, res);
        end
        checks++;
        assert (finish === 1'b0 && computing === 1'b0) else begin
            errors++;
            $display("Error %0t: finish=%b computing=%b after reset",
                     $time, finish, computing);
        end

        // Exact squares
        run_op(32'h4000_0000);  // 1.0
        run_op(32'h4100_0000);  // 4.0
        run_op(32'h4090_0000);  // 2.25
        run_op(32'h3F00_0000);  // 0.25
        run_op(32'h0080_0000);  // Smallest normal
        run_op(32'h7F7F_FFFF);  // Largest normal

        // Random operands with alternating exponent parity
        for (int i = 0; i < NUM_RANDOM; i++) begin
            e = exp_t'(2 + 2 * ($urandom % 126) + (i % 2));
            m = man_t'($urandom);
            run_op({1'b0, e, m});
        end

        if (timeouts == 0) begin
            busy_start_test(32'h4049_0FDB, 32'h3F00_0000);
        end

        checks++;
        assert (finish_seen == ops_done && pending.size() == 0) else begin
            errors++;
            $display("Error %0t: %0d finish pulses for %0d results, %0d unchecked",
                     $time, finish_seen, ops_done, pending.size());
        end

        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
